// ==== barTrigger.f ====
+incdir+verilog
verilog/detectorGeomPkg.sv
verilog/triggerRecordPkg.sv
verilog/hitHold.sv
verilog/layerCoincidence.sv
verilog/triggerFire.sv
verilog/triggerRecordStore.sv
verilog/barTrigger.sv
testbench/barTriggerTb.sv

// ==== Makefile ====
VERILATOR = verilator
TOP       = barTriggerTb
FILELIST  = barTrigger.f
FLAGS     = --binary --timing --assert -Wno-fatal
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SOURCES   = $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== testbench/barTriggerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module barTriggerTb;

	localparam int NUM_PHASES     = 12;
	localparam int PHASE_LEN      = 300; // cycles per phase
	localparam int RESET_CYCLES   = 10;
	localparam int SETTLE_CYCLES  = 40;  // old pulses and holds drained by then
	localparam int TIMEOUT_CYCLES = NUM_PHASES*PHASE_LEN + RESET_CYCLES + 200;
	localparam int LAYER_CH       = `NUM_LAYERS*`BARS_PER_LAYER;

	// DUT inputs
	logic                           clk_adc;
	logic                           resetClock2;
	logic [`NUM_CHANNELS-1:0]       coaxIn;      // active low and idle high
	logic [`NUM_CHANNELS-1:0]       triggerMask;
	logic [`HOLD_WIDTH-1:0]         holdTime;
	logic [`NUM_TRIG_BITS-1:0]      triggerEnable;
	logic [`DEAD_WIDTH-1:0]         deadTime;
	logic [`RAND_WIDTH-1:0]         randNum;
	logic [`RAND_WIDTH-1:0]         prescale;
	logic [`RECORD_INDEX_WIDTH-1:0] readIndex;
	// DUT outputs
	logic [`OUT_CHANNELS-1:0]       coaxOut;
	logic [`RECORD_COUNT_WIDTH-1:0] recordCount;
	logic                           recordOverflow;
	logic [`NUM_TRIG_BITS-1:0]      readBits;
	logic [`TIMESTAMP_WIDTH-1:0]    readTime;

	// run bookkeeping
	int   errorCount;
	int   checkCount;
	int   cycleCount;
	int   resetLeft;  // reset edges still to apply
	int   runLen;     // current coaxOut high run
	int   phaseRises; // pulse starts seen after settling
	int   phaseCycle;
	logic prevPulse;
	logic overflowSeen;
	logic [31:0] lfsr;

	// phase settings that go out with the next input update
	logic [`NUM_TRIG_BITS-1:0] cfgEnable;
	logic [`DEAD_WIDTH-1:0]    cfgDead;
	logic [`HOLD_WIDTH-1:0]    cfgHold;
	logic [`RAND_WIDTH-1:0]    cfgPrescale;
	logic [`NUM_CHANNELS-1:0]  cfgMask;
	logic                      busyOff; // channel 63 left idle

	////////////////////
	// model state with one variable per DUT register
	logic [`NUM_CHANNELS-1:0]    mHitReg;
	logic [`HOLD_WIDTH-1:0]      mHold [`NUM_CHANNELS];
	logic [`NUM_TRIG_BITS-1:0]   mCond;
	logic                        mPass;
	logic [`DEAD_WIDTH-1:0]      mDead [`NUM_TRIG_BITS];
	int                          mPulse;
	logic [`OUT_CHANNELS-1:0]    mCoaxOut;
	logic [`TIMESTAMP_WIDTH-1:0] mTs;
	logic                        mRecOpen;
	int                          mFirst;
	logic [`NUM_TRIG_BITS-1:0]   mOpenBits;
	logic [`TIMESTAMP_WIDTH-1:0] mOpenTime;
	logic                        mRecWrite;
	logic [`NUM_TRIG_BITS-1:0]   mRecBits;
	logic [`TIMESTAMP_WIDTH-1:0] mRecTime;
	int                          mCount;
	logic                        mOverflow;
	logic [`NUM_TRIG_BITS-1:0]   memBits [`RECORD_DEPTH];
	logic [`TIMESTAMP_WIDTH-1:0] memTime [`RECORD_DEPTH];

	barTrigger barTrigger_i (
		.clk_adc        (clk_adc),
		.resetClock2    (resetClock2),
		.coaxIn         (coaxIn),
		.triggerMask    (triggerMask),
		.holdTime       (holdTime),
		.triggerEnable  (triggerEnable),
		.deadTime       (deadTime),
		.randNum        (randNum),
		.prescale       (prescale),
		.readIndex      (readIndex),
		.coaxOut        (coaxOut),
		.recordCount    (recordCount),
		.recordOverflow (recordOverflow),
		.readBits       (readBits),
		.readTime       (readTime)
	);

	initial begin
		clk_adc = 1'b0;
		forever #10 clk_adc = ~clk_adc; // 20 ns period
	end

	////////////////////
	// galois lfsr stepped once per random bit
	function automatic logic randBit();
		logic lsb;
		lsb  = lfsr[0];
		lfsr = lfsr >> 1;
		if (lsb) lfsr = lfsr ^ 32'h80200003; // x^32+x^22+x^2+x+1
		return lsb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], randBit()};
		end
		return v;
	endfunction

	task automatic reportMismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
		errorCount++;
		$display("Mismatch: %s got %h expected %h at cycle %0d", sig, got, exp, cycleCount);
	endtask

	task automatic resetModel();
		mHitReg = '0;
		for (int n = 0; n < `NUM_CHANNELS; n++) mHold[n] = '0;
		for (int b = 0; b < `NUM_TRIG_BITS; b++) mDead[b] = '0;
		mCond     = '0;
		mPass     = 1'b0;
		mPulse    = 0;
		mCoaxOut  = '0;
		mTs       = '0;
		mRecOpen  = 1'b0;
		mFirst    = 0;
		mOpenBits = '0;
		mOpenTime = '0;
		mRecWrite = 1'b0;
		mRecBits  = '0;
		mRecTime  = '0;
		mCount    = 0; // entries stay and only the count clears
		mOverflow = 1'b0;
	endtask

	////////////////////
	// one clock edge of the model with every stage fed from the old state
	task automatic stepModel();
		logic [LAYER_CH-1:0]       lh;
		logic [`NUM_LAYERS-1:0]    layAny;
		logic [`NUM_TRIG_BITS-1:0] condNext;
		logic [`NUM_TRIG_BITS-1:0] fire;
		logic                      rowHit;
		logic                      anyDead;
		int                        nLay;
		int                        depth;
		if (resetClock2) begin
			resetModel();
		end else begin
			for (int n = 0; n < LAYER_CH; n++) lh[n] = (mHold[n] > `HOLD_THRESHOLD);
			nLay = 0;
			for (int l = 0; l < `NUM_LAYERS; l++) begin
				layAny[l] = (lh[l*`BARS_PER_LAYER +: `BARS_PER_LAYER] != '0);
				if (layAny[l]) nLay++;
			end
			rowHit = 1'b0;
			for (int b = 0; b < `BARS_PER_LAYER; b++) begin // layers hit at one bar position
				depth = 0;
				for (int l = 0; l < `NUM_LAYERS; l++) begin
					if (lh[l*`BARS_PER_LAYER+b]) depth++;
				end
				if (depth > 2) rowHit = 1'b1;
			end
			condNext[0] = (nLay == `NUM_LAYERS);
			condNext[1] = rowHit;
			condNext[2] = (layAny[0] && layAny[2]) || (layAny[1] && layAny[3]);
			condNext[3] = (layAny[0] && layAny[1]) || (layAny[1] && layAny[2]) ||
			              (layAny[2] && layAny[3]);
			condNext[4] = (nLay != 0);

			anyDead = 1'b0;
			for (int b = 0; b < `NUM_TRIG_BITS; b++) begin
				fire[b] = triggerEnable[b] && (mDead[b] == '0) && mCond[b] &&
				          mHitReg[`BUSY_CHANNEL] && mPass;
				if (mDead[b] != '0) anyDead = 1'b1;
			end

			// store takes last cycle's strobe
			if (mRecWrite) begin
				if (mCount < `RECORD_DEPTH) begin
					memBits[mCount] = mRecBits;
					memTime[mCount] = mRecTime;
					mCount++;
				end else begin
					mOverflow = 1'b1;
				end
			end

			mRecWrite = 1'b0;
			if (!mRecOpen) begin
				if (fire != '0) begin
					mRecOpen = 1'b1;
					for (int b = `NUM_TRIG_BITS-1; b >= 0; b--) begin
						if (fire[b]) mFirst = b; // lowest firing bit
					end
					mOpenBits = fire;
					mOpenTime = mTs;
				end
			end else begin
				mOpenBits = mOpenBits | fire;
				if (mDead[mFirst] == `DEAD_WIDTH'(1)) begin // first bit leaves dead time
					mRecWrite = 1'b1;
					mRecBits  = mOpenBits;
					mRecTime  = mOpenTime;
					mRecOpen  = 1'b0;
				end
			end

			mCoaxOut = (mPulse != 0) ? '1 : '0; // one cycle behind the counter
			if ((fire != '0) && !anyDead && (mPulse == 0)) begin
				mPulse = `OUT_PULSE_LEN;
			end else if (mPulse != 0) begin
				mPulse--;
			end

			for (int b = 0; b < `NUM_TRIG_BITS; b++) begin
				if (fire[b]) mDead[b] = deadTime;
				else if (mDead[b] != '0) mDead[b] = mDead[b] - `DEAD_WIDTH'(1);
			end
			mCond = condNext;
			mPass = (randNum <= prescale);

			for (int n = 0; n < `NUM_CHANNELS; n++) begin
				if (mHitReg[n]) mHold[n] = holdTime;
				else if (mHold[n] != '0) mHold[n] = mHold[n] - `HOLD_WIDTH'(1);
			end
			mHitReg = ~coaxIn & triggerMask; // inverted then masked
			mTs     = mTs + `TIMESTAMP_WIDTH'(1);
		end
	endtask

	////////////////////
	// stimulus
	task automatic driveInputs();
		logic [`NUM_CHANNELS-1:0] lowMask; // channels pulled low this cycle
		int bar;
		lowMask = '0;
		if (randBits(4) == 0) begin // straight track through the same bar in every layer
			bar = int'(randBits(3));
			for (int l = 0; l < `NUM_LAYERS; l++) lowMask[l*`BARS_PER_LAYER+bar] = 1'b1;
		end
		for (int l = 0; l < `NUM_LAYERS; l++) begin
			if (randBits(3) == 0) lowMask[l*`BARS_PER_LAYER + int'(randBits(3))] = 1'b1;
		end
		if (randBits(3) == 0) lowMask[LAYER_CH + int'(randBits(5) % 31)] = 1'b1; // spare 32..62
		if (!busyOff && randBits(4) != 0) lowMask[`BUSY_CHANNEL] = 1'b1; // busy most cycles
		coaxIn        = ~lowMask;
		randNum       = randBits(32);
		readIndex     = `RECORD_INDEX_WIDTH'(randBits(3));
		triggerEnable = cfgEnable;
		deadTime      = cfgDead;
		holdTime      = cfgHold;
		prescale      = cfgPrescale;
		triggerMask   = cfgMask;
		resetClock2   = (resetLeft > 0);
		if (resetLeft > 0) resetLeft--;
	endtask

	////////////////////
	// checks
	task automatic checkOutputs();
		checkCount++;
		if (coaxOut !== mCoaxOut) reportMismatch("coaxOut", 64'(coaxOut), 64'(mCoaxOut));
		if (recordCount !== `RECORD_COUNT_WIDTH'(mCount))
			reportMismatch("recordCount", 64'(recordCount), 64'(mCount));
		if (recordOverflow !== mOverflow)
			reportMismatch("recordOverflow", 64'(recordOverflow), 64'(mOverflow));
		if (resetClock2) begin
			runLen = 0;
		end else if (coaxOut[0] === 1'b1) begin
			runLen++;
		end else begin
			if (runLen != 0 && runLen != `OUT_PULSE_LEN) begin
				errorCount++;
				$display("output pulse lasted %0d cycles instead of %0d", runLen, `OUT_PULSE_LEN);
			end
			runLen = 0;
		end
		if (coaxOut[0] === 1'b1 && !prevPulse && phaseCycle >= SETTLE_CYCLES) phaseRises++;
		prevPulse = (coaxOut[0] === 1'b1);
		if (recordOverflow === 1'b1) overflowSeen = 1'b1;
	endtask

	task automatic checkReadPort();
		if (int'(readIndex) < mCount) begin // only filled entries are defined
			if (readBits !== memBits[readIndex])
				reportMismatch("readBits", 64'(readBits), 64'(memBits[readIndex]));
			if (readTime !== memTime[readIndex])
				reportMismatch("readTime", 64'(readTime), 64'(memTime[readIndex]));
		end
	endtask

	task automatic runCycle();
		@(posedge clk_adc);
		stepModel();
		#2;
		checkOutputs();
		driveInputs();
		#1;
		checkReadPort();
	endtask

	// every index in turn between two edges
	task automatic sweepStore();
		for (int i = 0; i < `RECORD_DEPTH; i++) begin
			readIndex = `RECORD_INDEX_WIDTH'(i);
			#1;
			checkReadPort();
		end
	endtask

	task automatic setupPhase(input int p);
		if (p < `NUM_TRIG_BITS) begin
			cfgEnable = `NUM_TRIG_BITS'(1) << p; // one condition alone
		end else begin
			cfgEnable = `NUM_TRIG_BITS'(randBits(5));
			if (cfgEnable == '0) cfgEnable = '1;
		end
		cfgDead     = `DEAD_WIDTH'(2 + randBits(5) % 19);  // 2..20
		cfgHold     = `HOLD_WIDTH'(4 + randBits(4) % 9);   // 4..12
		cfgPrescale = '1;
		if (p == 6 || (p > 8 && randBit())) cfgPrescale = randBits(32);
		busyOff = (p == 5);
		cfgMask = '1;
		if (p == 8) cfgMask[LAYER_CH-1:0] = '0; // every layer channel off
		if (p > 8) cfgMask[LAYER_CH-1:0] = randBits(32);
		if (p == 7) begin
			sweepStore();
			resetLeft = RESET_CYCLES; // reset in the middle of the run
		end
		phaseRises = 0;
	endtask

	task automatic endPhase(input int p);
		if ((p == 5 || p == 8) && phaseRises != 0) begin
			errorCount++;
			$display("output pulse in phase %0d although every trigger is blocked", p);
		end
		if (p < `NUM_TRIG_BITS && phaseRises == 0) begin
			errorCount++;
			$display("no output pulse in phase %0d with only trigger bit %0d enabled", p, p);
		end
	endtask

	////////////////////
	// timeout
	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk_adc);
			cycleCount++;
		end
		$display("timeout: run still going after %0d cycles", cycleCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

	////////////////////
	// main sequence
	initial begin
		lfsr          = 32'ha0e0;
		errorCount    = 0;
		checkCount    = 0;
		runLen        = 0;
		phaseRises    = 0;
		phaseCycle    = 0;
		prevPulse     = 1'b0;
		overflowSeen  = 1'b0;
		resetClock2   = 1'b1;
		resetLeft     = RESET_CYCLES - 1; // edge 1 plus nine more
		coaxIn        = '1;               // all inputs unconnected
		triggerMask   = '1;
		holdTime      = `HOLD_WIDTH'(8);
		triggerEnable = '0;
		deadTime      = `DEAD_WIDTH'(4);
		randNum       = '0;
		prescale      = '1;
		readIndex     = '0;
		cfgEnable     = '0;
		cfgDead       = `DEAD_WIDTH'(4);
		cfgHold       = `HOLD_WIDTH'(8);
		cfgPrescale   = '1;
		cfgMask       = '1;
		busyOff       = 1'b0;
		resetModel();

		for (int c = 0; c < RESET_CYCLES; c++) runCycle();
		for (int p = 0; p < NUM_PHASES; p++) begin
			setupPhase(p);
			for (int c = 0; c < PHASE_LEN; c++) begin
				phaseCycle = c;
				runCycle();
			end
			endPhase(p);
		end
		sweepStore();
		if (!overflowSeen) begin
			errorCount++;
			$display("record store never reached overflow");
		end

		$display("run done: %0d cycles checked, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/barTrigger.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module barTrigger (
	input  wire                                clk_adc,
	input  wire                                resetClock2,
	input  wire detectorGeomPkg::channelVec_t  coaxIn,
	input  wire detectorGeomPkg::channelVec_t  triggerMask,
	input  wire detectorGeomPkg::holdTimer_t   holdTime,
	input  wire triggerRecordPkg::trigBits_t   triggerEnable,
	input  wire triggerRecordPkg::deadCount_t  deadTime,
	input  wire [`RAND_WIDTH-1:0]              randNum,
	input  wire [`RAND_WIDTH-1:0]              prescale,
	input  wire [`RECORD_INDEX_WIDTH-1:0]      readIndex,
	output logic [`OUT_CHANNELS-1:0]           coaxOut,
	output logic [`RECORD_COUNT_WIDTH-1:0]     recordCount,
	output logic                               recordOverflow,
	output triggerRecordPkg::trigBits_t        readBits,
	output triggerRecordPkg::timestamp_t       readTime
);

	import detectorGeomPkg::*;
	import triggerRecordPkg::*;

	layerHits_t layerHits;   // hitHold -> layerCoincidence
	logic       busy;        // channel 63, straight to triggerFire
	trigCond_u  cond;        // layerCoincidence -> triggerFire
	logic       recordWrite; // triggerFire -> store
	trigBits_t  recordBits;
	timestamp_t recordTime;

	////////////////////
	// producer chain
	hitHold hitHold_i (
		.clk_adc     (clk_adc),
		.resetClock2 (resetClock2),
		.coaxIn      (coaxIn),
		.triggerMask (triggerMask),
		.holdTime    (holdTime),
		.layerHits   (layerHits),
		.busy        (busy)
	);

	layerCoincidence layerCoincidence_i (
		.clk_adc     (clk_adc),
		.resetClock2 (resetClock2),
		.layerHits   (layerHits),
		.cond        (cond)
	);

	triggerFire triggerFire_i (
		.clk_adc       (clk_adc),
		.resetClock2   (resetClock2),
		.cond          (cond),
		.busy          (busy),
		.triggerEnable (triggerEnable),
		.deadTime      (deadTime),
		.randNum       (randNum),
		.prescale      (prescale),
		.coaxOut       (coaxOut),
		.recordWrite   (recordWrite),
		.recordBits    (recordBits),
		.recordTime    (recordTime)
	);

	// buffer, read by the host through readIndex
	triggerRecordStore triggerRecordStore_i (
		.clk_adc        (clk_adc),
		.resetClock2    (resetClock2),
		.recordWrite    (recordWrite),
		.recordBits     (recordBits),
		.recordTime     (recordTime),
		.readIndex      (readIndex),
		.recordCount    (recordCount),
		.recordOverflow (recordOverflow),
		.readBits       (readBits),
		.readTime       (readTime)
	);

endmodule

`default_nettype wire

// ==== verilog/triggerRecordStore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module triggerRecordStore (
	input  wire                                clk_adc,
	input  wire                                resetClock2,
	input  wire                                recordWrite,  // strobe from triggerFire
	input  wire triggerRecordPkg::trigBits_t   recordBits,
	input  wire triggerRecordPkg::timestamp_t  recordTime,
	input  wire [`RECORD_INDEX_WIDTH-1:0]      readIndex,    // host read address
	output logic [`RECORD_COUNT_WIDTH-1:0]     recordCount,  // entries filled
	output logic                               recordOverflow,
	output triggerRecordPkg::trigBits_t        readBits,
	output triggerRecordPkg::timestamp_t       readTime
);

	import triggerRecordPkg::*;

	trigBits_t  bitsMem [`RECORD_DEPTH];
	timestamp_t timeMem [`RECORD_DEPTH];

	logic full;

	assign full = (recordCount >= `RECORD_DEPTH); // stop-when-full, no wrap

	////////////////////
	// fill count and overflow
	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			recordCount    <= '0;
			recordOverflow <= 1'b0;
		end else if (recordWrite) begin
			if (!full)
				recordCount <= recordCount + 1'b1;
			else
				recordOverflow <= 1'b1; // sticky until reset
		end
	end

	// entries
	always_ff @(posedge clk_adc) begin
		if (recordWrite && !full && !resetClock2) begin
			bitsMem[recordCount[`RECORD_INDEX_WIDTH-1:0]] <= recordBits;
			timeMem[recordCount[`RECORD_INDEX_WIDTH-1:0]] <= recordTime;
		end
	end

	// read port, combinational on the index
	assign readBits = bitsMem[readIndex];
	assign readTime = timeMem[readIndex];

	countBound: assert property (@(posedge clk_adc) disable iff (resetClock2)
		recordCount <= `RECORD_DEPTH)
		else $error("recordCount %0d past store depth", recordCount);

endmodule

`default_nettype wire

// ==== verilog/triggerFire.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module triggerFire (
	input  wire                                clk_adc,
	input  wire                                resetClock2,
	input  wire triggerRecordPkg::trigCond_u   cond,          // layer conditions, bit = trigger
	input  wire                                busy,          // channel 63 level
	input  wire triggerRecordPkg::trigBits_t   triggerEnable,
	input  wire triggerRecordPkg::deadCount_t  deadTime,      // must be at least 1
	input  wire [`RAND_WIDTH-1:0]              randNum,
	input  wire [`RAND_WIDTH-1:0]              prescale,      // max value passes everything
	output logic [`OUT_CHANNELS-1:0]           coaxOut,
	output logic                               recordWrite,   // one-cycle strobe
	output triggerRecordPkg::trigBits_t        recordBits,
	output triggerRecordPkg::timestamp_t       recordTime
);

	import triggerRecordPkg::*;

	localparam int PULSE_CNT_WIDTH = $clog2(`OUT_PULSE_LEN + 1);

	logic        passPrescale;                // registered alongside cond
	deadCount_t  deadCnt [`NUM_TRIG_BITS];    // per-bit dead time
	logic [PULSE_CNT_WIDTH-1:0] pulseCnt;     // shared output pulse
	timestamp_t  timestampCnt;                // cycles since reset

	logic        recOpen;                     // a record is collecting bits
	trigIndex_t  firstBit;                    // bit that opened it
	trigBits_t   openBits;
	timestamp_t  openTime;

	trigBits_t   fire;                        // bits firing at this edge
	logic        anyDead;

	// lowest set bit wins the record
	function automatic trigIndex_t lowestBit(input trigBits_t bits);
		trigIndex_t idx;
		idx = '0;
		for (int b = `NUM_TRIG_BITS-1; b >= 0; b--) begin
			if (bits[b]) idx = trigIndex_t'(b);
		end
		return idx;
	endfunction

	////////////////////
	// firing decisions
	always_comb begin
		anyDead = 1'b0;
		for (int b = 0; b < `NUM_TRIG_BITS; b++) begin
			fire[b] = triggerEnable[b] && (deadCnt[b] == '0) && cond.bits[b] &&
			          busy && passPrescale;
			if (deadCnt[b] != '0) anyDead = 1'b1;
		end
	end

	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			passPrescale <= 1'b0;
			for (int b = 0; b < `NUM_TRIG_BITS; b++) begin
				deadCnt[b] <= '0;
			end
			pulseCnt     <= '0;
			coaxOut      <= '0;
			timestampCnt <= '0;
			recOpen      <= 1'b0;
			firstBit     <= '0;
			openBits     <= '0;
			openTime     <= '0;
			recordWrite  <= 1'b0;
			recordBits   <= '0;
			recordTime   <= '0;
		end else begin
			passPrescale <= (randNum <= prescale); // same randNum cycle that cond samples
			timestampCnt <= timestampCnt + timestamp_t'(1);

			for (int b = 0; b < `NUM_TRIG_BITS; b++) begin
				if (fire[b])
					deadCnt[b] <= deadTime; // refire earliest deadTime+1 edges later
				else if (deadCnt[b] != '0)
					deadCnt[b] <= deadCnt[b] - 1'b1;
			end

			// new pulse only from a fully idle state, so one pulse never runs into the next
			if ((fire != '0) && !anyDead && (pulseCnt == '0))
				pulseCnt <= PULSE_CNT_WIDTH'(`OUT_PULSE_LEN);
			else if (pulseCnt != '0)
				pulseCnt <= pulseCnt - 1'b1;
			coaxOut <= {`OUT_CHANNELS{pulseCnt != '0}}; // all outputs together, one cycle late

			////////////////////
			// record assembly
			recordWrite <= 1'b0;
			if (!recOpen) begin
				if (fire != '0) begin
					recOpen  <= 1'b1;
					firstBit <= lowestBit(fire);
					openBits <= fire;
					openTime <= timestampCnt; // time of the opening edge
				end
			end else begin
				openBits <= openBits | fire;
				if (deadCnt[firstBit] == deadCount_t'(1)) begin // first bit leaves dead time
					recordWrite <= 1'b1;
					recordBits  <= openBits | fire; // late bits on the closing edge count too
					recordTime  <= openTime;
					recOpen     <= 1'b0;
				end
			end
		end
	end

	// a pulse is exactly OUT_PULSE_LEN wide, never stretched
	pulseLength: assert property (@(posedge clk_adc) disable iff (resetClock2)
		$rose(coaxOut[0]) |-> coaxOut[0] [*`OUT_PULSE_LEN] ##1 !coaxOut[0])
		else $error("output pulse longer than %0d cycles", `OUT_PULSE_LEN);

	recordNotEmpty: assert property (@(posedge clk_adc) disable iff (resetClock2)
		recordWrite |-> (recordBits != '0))
		else $error("record written with no fired bits");

	// with deadTime 0 the first bit never counts 1->0, so the record would never close
	noZeroDead: assert property (@(posedge clk_adc) disable iff (resetClock2)
		(fire != '0) |-> (deadTime != '0))
		else $error("trigger fired with deadTime 0");

endmodule

`default_nettype wire

// ==== verilog/layerCoincidence.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module layerCoincidence (
	input  wire                              clk_adc,
	input  wire                              resetClock2,
	input  wire detectorGeomPkg::layerHits_t layerHits, // held hits, channels 0..31
	output triggerRecordPkg::trigCond_u     cond        // registered layer conditions
);

	import detectorGeomPkg::*;

	localparam int ROW_MIN_LAYERS = 3; // threeInRow: more than 2 layers at one bar position

	layerCount_t layerCount [`NUM_LAYERS];     // bars hit per layer
	posCount_t   posCount   [`BARS_PER_LAYER]; // layers hit per bar position
	logic [`NUM_LAYERS-1:0] layerAny;          // layer has any bar hit
	posCount_t   layersHit;                    // number of layers with a hit

	logic rowNext;      // some bar position deep enough
	logic adjacentNext; // some neighbouring pair hit

	////////////////////
	// counting
	always_comb begin
		for (int l = 0; l < `NUM_LAYERS; l++) begin
			layerCount[l] = '0;
			for (int b = 0; b < `BARS_PER_LAYER; b++) begin
				layerCount[l] = layerCount[l] + layerCount_t'(layerHits[l*`BARS_PER_LAYER+b]);
			end
			layerAny[l] = (layerCount[l] != '0);
		end

		// same bar index across layers, i.e. one projective line
		for (int b = 0; b < `BARS_PER_LAYER; b++) begin
			posCount[b] = '0;
			for (int l = 0; l < `NUM_LAYERS; l++) begin
				posCount[b] = posCount[b] + posCount_t'(layerHits[l*`BARS_PER_LAYER+b]);
			end
		end

		layersHit = '0;
		for (int l = 0; l < `NUM_LAYERS; l++) begin
			layersHit = layersHit + posCount_t'(layerAny[l]);
		end
	end

	always_comb begin
		rowNext = 1'b0;
		for (int b = 0; b < `BARS_PER_LAYER; b++) begin
			if (posCount[b] >= ROW_MIN_LAYERS) rowNext = 1'b1;
		end
		adjacentNext = 1'b0;
		for (int l = 0; l < `NUM_LAYERS-1; l++) begin
			if (layerAny[l] && layerAny[l+1]) adjacentNext = 1'b1; // 0-1, 1-2, 2-3
		end
	end

	////////////////////
	// condition register, written by name
	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			cond <= '0;
		end else begin
			cond.named.fourLayers      <= (layersHit == `NUM_LAYERS);
			cond.named.threeInRow      <= rowNext;
			cond.named.separatedLayers <= (layerAny[0] && layerAny[2]) ||
			                              (layerAny[1] && layerAny[3]); // skip one layer
			cond.named.adjacentLayers  <= adjacentNext;
			cond.named.anyLayer        <= (layersHit != '0);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/hitHold.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "barTrigger_params.svh"

module hitHold (
	input  wire                          clk_adc,
	input  wire                          resetClock2,
	input  wire detectorGeomPkg::channelVec_t coaxIn,      // active-low raw discriminator inputs
	input  wire detectorGeomPkg::channelVec_t triggerMask, // 1 = channel in use
	input  wire detectorGeomPkg::holdTimer_t  holdTime,    // hold length in cycles
	output detectorGeomPkg::layerHits_t  layerHits,
	output logic                         busy
);

	import detectorGeomPkg::*;

	channelVec_t hitReg;                    // conditioned inputs, one stage
	holdTimer_t  holdTimer [`NUM_CHANNELS]; // per-channel hold

	////////////////////
	// input conditioning
	// inverted so an unconnected (high) input reads as 0 and masked channels stay 0
	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			hitReg <= '0;
		end else begin
			hitReg <= ~coaxIn & triggerMask;
		end
	end

	////////////////////
	// hold timers
	always_ff @(posedge clk_adc) begin
		if (resetClock2) begin
			for (int n = 0; n < `NUM_CHANNELS; n++) begin
				holdTimer[n] <= '0;
			end
		end else begin
			for (int n = 0; n < `NUM_CHANNELS; n++) begin
				if (hitReg[n])
					holdTimer[n] <= holdTime; // retrigger restarts the hold
				else if (holdTimer[n] != '0)
					holdTimer[n] <= holdTimer[n] - 1'b1; // count down to idle
			end
		end
	end

	// only the layer channels feed the coincidence logic
	always_comb begin
		for (int n = 0; n < `NUM_LAYERS*`BARS_PER_LAYER; n++) begin
			layerHits[n] = (holdTimer[n] > `HOLD_THRESHOLD); // drops out before the timer hits 0
		end
	end

	assign busy = hitReg[`BUSY_CHANNEL]; // taken straight from the register without a hold

	// a timer rises only when loaded and then to at most holdTime, so it never wraps below 0
	for (genvar n = 0; n < `NUM_CHANNELS; n++) begin : gHoldCheck
		holdLoadBound: assert property (@(posedge clk_adc) disable iff (resetClock2)
			(holdTimer[n] > $past(holdTimer[n])) |->
				($past(hitReg[n]) && (holdTimer[n] <= $past(holdTime))))
			else $error("hold timer %0d rose without a load or above holdTime", n);
	end

endmodule

`default_nettype wire

// ==== verilog/triggerRecordPkg.sv ====
`default_nettype none

`include "barTrigger_params.svh"

package triggerRecordPkg;

	// condition fields by name, anyLayer is the msb so fourLayers lands on bit 0
	typedef struct packed {
		logic anyLayer;        // bit 4
		logic adjacentLayers;  // bit 3
		logic separatedLayers; // bit 2
		logic threeInRow;      // bit 1
		logic fourLayers;      // bit 0
	} trigCond_s;

	// same word seen two ways: named when built, indexed by trigger number when used
	typedef union packed {
		trigCond_s                  named;
		logic [`NUM_TRIG_BITS-1:0] bits;
	} trigCond_u;

	// fired-bit string, one bit per trigger
	typedef logic [`NUM_TRIG_BITS-1:0] trigBits_t;

	// index of a single trigger bit
	typedef logic [`TRIG_INDEX_WIDTH-1:0] trigIndex_t;

	// dead counter and deadTime
	typedef logic [`DEAD_WIDTH-1:0] deadCount_t;

	// cycle count of a record
	typedef logic [`TIMESTAMP_WIDTH-1:0] timestamp_t;

endpackage

`default_nettype wire

// ==== verilog/detectorGeomPkg.sv ====
`default_nettype none

`include "barTrigger_params.svh"

package detectorGeomPkg;

	// one bit per discriminator input
	typedef logic [`NUM_CHANNELS-1:0] channelVec_t;

	// hit flags of the layer channels only, 0..31
	typedef logic [`NUM_LAYERS*`BARS_PER_LAYER-1:0] layerHits_t;

	// per-channel hold timer, same width as holdTime
	typedef logic [`HOLD_WIDTH-1:0] holdTimer_t;

	// number of bars hit inside one layer, 0..BARS_PER_LAYER
	typedef logic [$clog2(`BARS_PER_LAYER+1)-1:0] layerCount_t;

	// number of layers hit, either at one bar position or overall
	typedef logic [$clog2(`NUM_LAYERS+1)-1:0] posCount_t;

endpackage

`default_nettype wire

// ==== verilog/barTrigger_params.svh ====
`ifndef BAR_TRIGGER_PARAMS_SVH
`define BAR_TRIGGER_PARAMS_SVH

////////////////////
// detector geometry
`define NUM_CHANNELS 64 // discriminator inputs
`define NUM_LAYERS 4
`define BARS_PER_LAYER 8 // layer L bar B sits on channel L*8+B
`define BUSY_CHANNEL 63 // must be high for anything to fire

////////////////////
// hit hold
`define HOLD_THRESHOLD 2 // timer must be above this to count as hit
`define HOLD_WIDTH 6 // hold timer and holdTime width

////////////////////
// trigger and output
`define OUT_CHANNELS 16 // coax outputs
`define OUT_PULSE_LEN 16 // output pulse length in cycles
`define NUM_TRIG_BITS 5
`define TRIG_INDEX_WIDTH 3 // enough to name any trigger bit
`define DEAD_WIDTH 8
`define RAND_WIDTH 32 // randNum and prescale

////////////////////
// record store
`define RECORD_DEPTH 8
`define RECORD_INDEX_WIDTH 3
`define RECORD_COUNT_WIDTH 4 // 0..RECORD_DEPTH
`define TIMESTAMP_WIDTH 52 // free-running cycle counter

`endif
